//--- Bender.yml
package:
  name: mem_subsystem

sources:
  - files:
      - hdl/mem_pkg.sv
      - hdl/dtlb.sv
      - hdl/data_cache.sv
      - hdl/mem_stage.sv
      - hdl/mem_subsystem.sv
  - target: test
    files:
      - bench/mem_model.sv
      - bench/mem_subsystem_tb.sv

//--- bench/mem_model.sv
module mem_model import mem_pkg::*; (
	input  logic              clock,
	input  logic              reset_i,
	input  logic              req_valid_i,
	output logic              req_ready_o,
	input  line_req_t         req_i,
	output logic              rvalid_o,
	output logic [LINE_W-1:0] rdata_o,
	output logic              wb_valid_o,
	output line_req_t         wb_o
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int MEM_LINES = 1024;                            // Four pages of physical memory

	logic [LINE_W-1:0] mem [MEM_LINES];
	integer seed;
	int wait_cnt;
	logic fire;
	line_req_t cur;
	logic [PHYS_ADDR_W-1:0] rd_addr;

	function automatic logic [7:0] fill_byte(int a);
		return 8'(a * 29) ^ 8'(a >> 7) ^ 8'h5a;
	endfunction

	initial begin
		seed = 38704;
		wait_cnt = 0;
		rd_addr = '0;
		req_ready_o = 1'b0;
		rvalid_o = 1'b0;
		rdata_o = '0;
		wb_valid_o = 1'b0;
		wb_o = '0;
		for (int i = 0; i < MEM_LINES * LINE_BYTES; i++) begin
			mem[i / LINE_BYTES][(i % LINE_BYTES) * 8 +: 8] = fill_byte(i);
		end
		forever begin
			@(negedge clock);
			fire = req_valid_i && req_ready_o && !reset_i;
			cur = req_i;
			@(posedge clock);
			#2;
			rvalid_o = 1'b0;
			wb_valid_o = 1'b0;
			if (wait_cnt > 0) begin
				wait_cnt--;
				if (wait_cnt == 0) begin
					rvalid_o = 1'b1;
					rdata_o = mem[rd_addr[13:4]];
				end
			end
			if (fire && cur.write) begin
				mem[cur.addr[13:4]] = cur.data;
				wb_o = cur;                                     // Kept for the bench to compare
				wb_valid_o = 1'b1;
			end else if (fire) begin
				rd_addr = cur.addr;
				wait_cnt = 2 + ($unsigned($random(seed)) % 5);
			end
			req_ready_o = (wait_cnt == 0) && (($random(seed) & 3) != 0);
		end
	end

endmodule

//--- bench/mem_subsystem_tb.sv
module mem_subsystem_tb import mem_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int RAND_OPS = 200;
	localparam int TIMEOUT_CYCLES = 20 * RAND_OPS;              // The random mix dominates the run
	localparam int MEM_BYTES = 16384;

	logic clock;
	logic reset_i;
	logic req_valid_i;
	logic req_ready_o;
	mem_req_t req_i;
	logic resp_valid_o;
	logic resp_ready_i;
	mem_resp_t resp_o;
	logic tlb_we_i;
	tlb_entry_t tlb_entry_i;
	logic mem_req_valid;
	logic mem_req_ready;
	line_req_t mem_req;
	logic mem_rvalid;
	logic [LINE_W-1:0] mem_rdata;
	logic wb_valid;
	line_req_t wb;

	integer stim_seed;
	integer ready_seed;
	logic rand_ready;
	int cycle_cnt;
	int start_cyc;
	int sent_cnt;
	int done_cnt;
	int wb_cnt;
	int cur_lat;
	string cur_name;
	logic lat_seen;
	logic [PHYS_ADDR_W-1:0] last_wb_addr;
	logic [7:0] shadow [MEM_BYTES];
	tlb_entry_t shadow_tlb [logic [VPN_W-1:0]];
	mem_resp_t exp_q [$];

	mem_subsystem dut0 (
		.clock, .reset_i, .req_valid_i, .req_ready_o, .req_i,
		.resp_valid_o, .resp_ready_i, .resp_o, .tlb_we_i, .tlb_entry_i,
		.mem_req_valid_o(mem_req_valid), .mem_req_ready_i(mem_req_ready), .mem_req_o(mem_req),
		.mem_rvalid_i(mem_rvalid), .mem_rdata_i(mem_rdata)
	);

	mem_model mem0 (
		.clock, .reset_i, .req_valid_i(mem_req_valid), .req_ready_o(mem_req_ready),
		.req_i(mem_req), .rvalid_o(mem_rvalid), .rdata_o(mem_rdata),
		.wb_valid_o(wb_valid), .wb_o(wb)
	);

	function automatic logic [7:0] fill_byte(int a);
		return 8'(a * 29) ^ 8'(a >> 7) ^ 8'h5a;
	endfunction

	function automatic logic [LINE_W-1:0] shadow_line(logic [PHYS_ADDR_W-1:0] a);
		logic [LINE_W-1:0] l;
		for (int b = 0; b < LINE_BYTES; b++) begin
			l[b*8 +: 8] = shadow[a[13:0] + b];
		end
		return l;
	endfunction

	function automatic mem_req_t make_req(logic [31:0] vaddr, logic [31:0] wdata, logic store,
			logic word, logic priv);
		mem_req_t r;
		r.vaddr = vaddr;
		r.wdata = wdata;
		r.store = store;
		r.word = word;
		r.priv = priv;
		return r;
	endfunction

	// Stores update the shadow memory as they are predicted
	function automatic mem_resp_t ref_resp(mem_req_t r);
		mem_resp_t e;
		tlb_entry_t t;
		int pa;
		e.rdata = '0;
		e.status = ST_OK;
		if (!shadow_tlb.exists(r.vaddr[31:12])) begin
			e.status = ST_TLB_MISS;
			return e;
		end
		t = shadow_tlb[r.vaddr[31:12]];
		if (t.kernel && !r.priv) begin
			e.status = ST_PRIV_FAULT;
			return e;
		end
		pa = {t.ppn, r.vaddr[11:0]};
		if (r.word) begin
			pa = pa & ~3;                                       // Words ignore the low address bits
		end
		for (int b = 0; b < (r.word ? 4 : 1); b++) begin
			if (r.store) begin
				shadow[pa + b] = r.wdata[b*8 +: 8];
			end else begin
				e.rdata[b*8 +: 8] = shadow[pa + b];
			end
		end
		return e;
	endfunction

	task automatic check_value(string name, logic [LINE_W-1:0] exp, logic [LINE_W-1:0] act);
		if (exp !== act) begin
			$display("error %s: expected %0h, actual %0h", name, exp, act);
			$display("STATUS: FAIL");
			$fatal(1, "value mismatch in %s", name);
		end
	endtask

	task automatic write_tlb(logic [VPN_W-1:0] vpn, logic [PPN_W-1:0] ppn, logic kernel);
		@(posedge clock);
		#2;
		tlb_entry_i.vpn = vpn;
		tlb_entry_i.ppn = ppn;
		tlb_entry_i.kernel = kernel;
		tlb_we_i = 1'b1;
		@(posedge clock);
		#2;
		tlb_we_i = 1'b0;
		shadow_tlb[vpn] = tlb_entry_i;
	endtask

	// A latency of zero leaves the response time unchecked
	task automatic issue(mem_req_t r, string name, int lat);
		@(posedge clock);
		#2;
		req_i = r;
		req_valid_i = 1'b1;
		@(negedge clock);
		while (!req_ready_o) begin
			@(negedge clock);
		end
		cur_name = name;
		cur_lat = lat;
		start_cyc = cycle_cnt;
		exp_q.push_back(ref_resp(r));
		sent_cnt++;
		@(posedge clock);
		#2;
		req_valid_i = 1'b0;
		wait (done_cnt == sent_cnt);
	endtask

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	initial begin
		cycle_cnt = 0;
		forever begin
			@(posedge clock);
			cycle_cnt++;
			if (cycle_cnt >= TIMEOUT_CYCLES) begin
				$display("timeout: the tests did not finish within %0d cycles", cycle_cnt);
				$display("STATUS: FAIL");
				$fatal(1, "timeout");
			end
		end
	end

	initial begin
		ready_seed = 38704;
		resp_ready_i = 1'b1;
		forever begin
			@(posedge clock);
			#2;
			resp_ready_i = rand_ready ? (($random(ready_seed) & 3) != 0) : 1'b1;
		end
	end

	// Write-backs and responses are both taken at the falling edge, where they are stable
	initial begin
		done_cnt = 0;
		wb_cnt = 0;
		lat_seen = 1'b0;
		last_wb_addr = '0;
		forever begin
			@(negedge clock);
			if (!reset_i && wb_valid) begin
				wb_cnt++;
				last_wb_addr = wb.addr;
				check_value("write-back data", shadow_line(wb.addr), wb.data);
			end
			if (!reset_i && resp_valid_o && exp_q.size() == 0) begin
				$display("a response arrived while no request was outstanding");
				$display("STATUS: FAIL");
				$fatal(1, "unexpected response");
			end else if (!reset_i && resp_valid_o) begin
				if (!lat_seen && cur_lat != 0) begin
					check_value({cur_name, " latency"}, cur_lat, cycle_cnt - start_cyc);
				end
				lat_seen = 1'b1;
				if (resp_ready_i) begin
					check_value(cur_name, exp_q.pop_front(), resp_o);
					lat_seen = 1'b0;
					done_cnt++;
				end
			end
		end
	end

	initial begin
		logic [31:0] rnd;
		logic [31:0] vaddr;
		int wb_before;
		stim_seed = 38704;
		rand_ready = 1'b0;
		sent_cnt = 0;
		start_cyc = 0;
		cur_lat = 0;
		cur_name = "";
		req_valid_i = 1'b0;
		req_i = '0;
		tlb_we_i = 1'b0;
		tlb_entry_i = '0;
		for (int a = 0; a < MEM_BYTES; a++) begin
			shadow[a] = fill_byte(a);
		end
		reset_i = 1'b1;
		repeat (3) @(posedge clock);
		#2;
		reset_i = 1'b0;

		issue(make_req(32'h1000_0084, 0, 1'b0, 1'b1, 1'b0), "unmapped load", 2);
		write_tlb(20'h10000, 8'd1, 1'b0);
		issue(make_req(32'h1000_0084, 0, 1'b0, 1'b1, 1'b0), "mapped load", 0);

		write_tlb(20'h20000, 8'd2, 1'b1);
		issue(make_req(32'h2000_0010, 0, 1'b0, 1'b1, 1'b0), "user on kernel page", 2);
		issue(make_req(32'h2000_0010, 0, 1'b0, 1'b1, 1'b1), "kernel on kernel page", 0);

		issue(make_req(32'h1000_0200, 32'hdead_beef, 1'b1, 1'b1, 1'b0), "word store", 0);
		issue(make_req(32'h1000_0201, 32'h0000_005c, 1'b1, 1'b0, 1'b0), "byte store", 3);
		issue(make_req(32'h1000_0200, 0, 1'b0, 1'b1, 1'b0), "merged word load", 3);
		issue(make_req(32'h1000_0203, 0, 1'b0, 1'b0, 1'b0), "byte load", 3);
		issue(make_req(32'h1000_0203, 0, 1'b0, 1'b0, 1'b0), "repeated byte load", 3);

		// Same index, different tag, so the dirty line has to leave
		issue(make_req(32'h1000_0040, 32'h1234_5678, 1'b1, 1'b1, 1'b0), "store before evict", 0);
		wb_before = wb_cnt;
		issue(make_req(32'h1000_0140, 0, 1'b0, 1'b1, 1'b0), "conflict load", 0);
		check_value("evict count", wb_before + 1, wb_cnt);
		check_value("evict address", 20'h01040, last_wb_addr);
		issue(make_req(32'h1000_0040, 0, 1'b0, 1'b1, 1'b0), "reload after evict", 0);

		rand_ready = 1'b1;
		for (int i = 0; i < RAND_OPS; i++) begin
			rnd = $random(stim_seed);
			vaddr = {rnd[8] ? 20'h20000 : 20'h10000, 4'h0, rnd[7:0]};
			issue(make_req(vaddr, $random(stim_seed), rnd[9], rnd[10], rnd[11]), "random mix", 0);
		end
		rand_ready = 1'b0;

		$display("STATUS: PASS");
		$finish;
	end

endmodule

//--- hdl/data_cache.sv
module data_cache import mem_pkg::*; (
	input  logic              clock,
	input  logic              reset_i,
	input  logic              req_valid_i,
	output logic              req_ready_o,
	input  cache_req_t        req_i,
	output logic              done_o,
	output logic [31:0]       rdata_o,
	output logic              mem_req_valid_o,
	input  logic              mem_req_ready_i,
	output line_req_t         mem_req_o,
	input  logic              mem_rvalid_i,
	input  logic [LINE_W-1:0] mem_rdata_i
);

	typedef enum logic [2:0] {
		C_IDLE,
		C_WRITEBACK,
		C_FILL_REQ,
		C_FILL_WAIT,
		C_REPLAY
	} cache_state_t;

	cache_state_t state_q;

	logic [LINE_W-1:0] data_q [CACHE_LINES];
	logic [TAG_W-1:0] tag_q [CACHE_LINES];
	logic [CACHE_LINES-1:0] valid_q;
	logic [CACHE_LINES-1:0] dirty_q;
	cache_req_t held_q;                                         // Access waiting for its line

	cache_req_t acc;
	logic [INDEX_W-1:0] idx;
	logic [TAG_W-1:0] tag;
	logic [WORD_SEL_W-1:0] wsel;
	logic hit;
	logic victim_dirty;
	logic do_access;
	logic start_miss;
	logic [LINE_W-1:0] cur_line;
	logic [LINE_W-1:0] new_line;
	logic [31:0] old_word;
	logic [31:0] new_word;
	line_req_t wb_req;
	line_req_t fill_req;

	assign acc = (state_q == C_IDLE) ? req_i : held_q;
	assign idx = acc.paddr[LINE_OFF_W +: INDEX_W];
	assign tag = acc.paddr[PHYS_ADDR_W-1 -: TAG_W];
	assign wsel = acc.paddr[2 +: WORD_SEL_W];
	assign hit = valid_q[idx] && (tag_q[idx] == tag);
	assign victim_dirty = valid_q[idx] && dirty_q[idx];

	assign req_ready_o = (state_q == C_IDLE);
	assign do_access = (req_ready_o && req_valid_i && hit) || (state_q == C_REPLAY);
	assign start_miss = req_ready_o && req_valid_i && !hit;

	always_comb begin
		cur_line = data_q[idx];
		old_word = cur_line[wsel*32 +: 32];
		for (int b = 0; b < 4; b++) begin
			new_word[b*8 +: 8] = acc.mask[b] ? acc.wdata[b*8 +: 8] : old_word[b*8 +: 8];
		end
		new_line = cur_line;
		new_line[wsel*32 +: 32] = new_word;
	end

	assign wb_req = '{addr: {tag_q[idx], idx, {LINE_OFF_W{1'b0}}}, write: 1'b1, data: cur_line};
	assign fill_req = '{addr: {tag, idx, {LINE_OFF_W{1'b0}}}, write: 1'b0, data: '0};

	always_ff @(posedge clock) begin
		if (reset_i) begin
			state_q <= C_IDLE;
			valid_q <= '0;
			dirty_q <= '0;
			mem_req_valid_o <= 1'b0;
			done_o <= 1'b0;
		end else begin
			done_o <= do_access;
			if (do_access && acc.store) begin
				dirty_q[idx] <= 1'b1;
			end
			case (state_q)
				C_IDLE: begin
					if (start_miss) begin
						mem_req_valid_o <= 1'b1;
						state_q <= victim_dirty ? C_WRITEBACK : C_FILL_REQ;
					end
				end
				C_WRITEBACK: begin
					if (mem_req_ready_i) begin
						state_q <= C_FILL_REQ;              // Valid stays up for the refill read
					end
				end
				C_FILL_REQ: begin
					if (mem_req_ready_i) begin
						mem_req_valid_o <= 1'b0;
						state_q <= C_FILL_WAIT;
					end
				end
				C_FILL_WAIT: begin
					if (mem_rvalid_i) begin
						valid_q[idx] <= 1'b1;
						dirty_q[idx] <= 1'b0;
						state_q <= C_REPLAY;
					end
				end
				default: state_q <= C_IDLE;                 // Replay hits on the fresh line
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (do_access) begin
			rdata_o <= old_word;
			if (acc.store) begin
				data_q[idx] <= new_line;
			end
		end
		if (start_miss) begin
			held_q <= req_i;
			mem_req_o <= victim_dirty ? wb_req : fill_req;
		end
		if (state_q == C_WRITEBACK && mem_req_ready_i) begin
			mem_req_o <= fill_req;
		end
		if (state_q == C_FILL_WAIT && mem_rvalid_i) begin
			data_q[idx] <= mem_rdata_i;
			tag_q[idx] <= tag;
		end
	end

	mem_req_hold_a: assert property (@(posedge clock) disable iff (reset_i)
		mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o));

endmodule

//--- hdl/dtlb.sv
module dtlb import mem_pkg::*; (
	input  logic             clock,
	input  logic             reset_i,
	input  logic             lookup_en_i,
	input  logic [VPN_W-1:0] lookup_vpn_i,
	output logic             hit_o,
	output logic [PPN_W-1:0] ppn_o,
	output logic             kernel_o,
	input  logic             tlb_we_i,
	input  tlb_entry_t       tlb_entry_i
);

	tlb_entry_t entry_q [TLB_ENTRIES];
	logic [TLB_ENTRIES-1:0] valid_q;
	logic [TLB_IDX_W-1:0] rr_q;                                 // Next victim slot

	logic [TLB_ENTRIES-1:0] lk_match;
	logic [TLB_ENTRIES-1:0] wr_match;
	logic [PPN_W-1:0] ppn_sel;
	logic kernel_sel;
	logic [TLB_IDX_W-1:0] wr_slot;

	// At most one entry can match, so the selected fields are a plain OR
	always_comb begin
		ppn_sel = '0;
		kernel_sel = 1'b0;
		wr_slot = rr_q;
		for (int i = 0; i < TLB_ENTRIES; i++) begin
			lk_match[i] = valid_q[i] && (entry_q[i].vpn == lookup_vpn_i);
			wr_match[i] = valid_q[i] && (entry_q[i].vpn == tlb_entry_i.vpn);
			if (lk_match[i]) begin
				ppn_sel |= entry_q[i].ppn;
				kernel_sel |= entry_q[i].kernel;
			end
			if (wr_match[i]) begin
				wr_slot = TLB_IDX_W'(i);                        // Refresh the existing mapping
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset_i) begin
			valid_q <= '0;
			rr_q <= '0;
			hit_o <= 1'b0;
		end else begin
			if (lookup_en_i) begin
				hit_o <= |lk_match;
			end
			if (tlb_we_i) begin
				valid_q[wr_slot] <= 1'b1;
				if (!(|wr_match)) begin
					rr_q <= rr_q + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (lookup_en_i) begin
			ppn_o <= ppn_sel;
			kernel_o <= kernel_sel;
		end
		if (tlb_we_i) begin
			entry_q[wr_slot] <= tlb_entry_i;
		end
	end

	// Overwrite on a vpn match keeps the mappings unique
	unique_map_a: assert property (@(posedge clock) disable iff (reset_i)
		$onehot0(lk_match) && $onehot0(wr_match));

endmodule

//--- hdl/mem_pkg.sv
package mem_pkg;

	localparam int PAGE_OFFSET = 12;
	localparam int VPN_W = 32 - PAGE_OFFSET;
	localparam int PPN_W = 8;
	localparam int PHYS_ADDR_W = PPN_W + PAGE_OFFSET;

	localparam int TLB_ENTRIES = 8;
	localparam int TLB_IDX_W = $clog2(TLB_ENTRIES);

	localparam int LINE_BYTES = 16;
	localparam int CACHE_LINES = 16;
	localparam int LINE_W = LINE_BYTES * 8;
	localparam int LINE_OFF_W = $clog2(LINE_BYTES);
	localparam int WORD_SEL_W = LINE_OFF_W - 2;                 // Words per line, as an index
	localparam int INDEX_W = $clog2(CACHE_LINES);
	localparam int TAG_W = PHYS_ADDR_W - INDEX_W - LINE_OFF_W;

	// Load or store coming from the execute stage
	typedef struct packed {
		logic [31:0] vaddr;
		logic [31:0] wdata;
		logic        store;
		logic        word;                                      // Clear for a byte access
		logic        priv;                                      // Set when running in kernel mode
	} mem_req_t;

	typedef enum logic [1:0] {
		ST_OK,
		ST_TLB_MISS,
		ST_PRIV_FAULT
	} mem_status_t;

	typedef struct packed {
		logic [31:0] rdata;
		mem_status_t status;
	} mem_resp_t;

	typedef struct packed {
		logic [VPN_W-1:0] vpn;
		logic [PPN_W-1:0] ppn;
		logic             kernel;
	} tlb_entry_t;

	// Access handed from the stage to the cache, already translated
	typedef struct packed {
		logic [PHYS_ADDR_W-1:0] paddr;
		logic                   store;
		logic [3:0]             mask;                           // One bit per byte lane
		logic [31:0]            wdata;                          // Already placed in its lane
	} cache_req_t;

	typedef struct packed {
		logic [PHYS_ADDR_W-1:0] addr;                           // Line aligned
		logic                   write;
		logic [LINE_W-1:0]      data;
	} line_req_t;

endpackage

//--- hdl/mem_stage.sv
module mem_stage import mem_pkg::*; (
	input  logic             clock,
	input  logic             reset_i,
	input  logic             req_valid_i,
	output logic             req_ready_o,
	input  mem_req_t         req_i,
	output logic             resp_valid_o,
	input  logic             resp_ready_i,
	output mem_resp_t        resp_o,
	output logic             lookup_en_o,
	output logic [VPN_W-1:0] lookup_vpn_o,
	input  logic             tlb_hit_i,
	input  logic [PPN_W-1:0] tlb_ppn_i,
	input  logic             tlb_kernel_i,
	output logic             cache_valid_o,
	input  logic             cache_ready_i,
	output cache_req_t       cache_req_o,
	input  logic             cache_done_i,
	input  logic [31:0]      cache_rdata_i
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_TRANSLATE,
		S_ACCESS,
		S_RESPOND
	} stage_state_t;

	stage_state_t state_q;
	mem_req_t req_q;
	mem_resp_t resp_q;
	logic priv_fault;
	logic [7:0] load_byte;

	assign req_ready_o = (state_q == S_IDLE);
	assign resp_valid_o = (state_q == S_RESPOND);
	assign resp_o = resp_q;

	// The TLB looks up in the transfer cycle itself
	assign lookup_en_o = req_valid_i && req_ready_o;
	assign lookup_vpn_o = req_i.vaddr[31:PAGE_OFFSET];

	assign priv_fault = tlb_kernel_i && !req_q.priv;
	assign cache_valid_o = (state_q == S_TRANSLATE) && tlb_hit_i && !priv_fault;
	assign cache_req_o.paddr = {tlb_ppn_i, req_q.vaddr[PAGE_OFFSET-1:0]};
	assign cache_req_o.store = req_q.store;
	assign cache_req_o.mask = req_q.word ? 4'b1111 : (4'b0001 << req_q.vaddr[1:0]);
	assign cache_req_o.wdata = req_q.word ? req_q.wdata : {4{req_q.wdata[7:0]}};

	assign load_byte = cache_rdata_i[{req_q.vaddr[1:0], 3'b000} +: 8];

	always_ff @(posedge clock) begin
		if (reset_i) begin
			state_q <= S_IDLE;
		end else begin
			case (state_q)
				S_IDLE: if (lookup_en_o) state_q <= S_TRANSLATE;
				S_TRANSLATE: begin
					if (!tlb_hit_i || priv_fault) begin
						state_q <= S_RESPOND;
					end else if (cache_ready_i) begin
						state_q <= S_ACCESS;
					end
				end
				S_ACCESS: if (cache_done_i) state_q <= S_RESPOND;
				default: if (resp_ready_i) state_q <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (lookup_en_o) begin
			req_q <= req_i;
		end
		if (state_q == S_TRANSLATE && !tlb_hit_i) begin
			resp_q <= '{rdata: '0, status: ST_TLB_MISS};
		end else if (state_q == S_TRANSLATE && priv_fault) begin
			resp_q <= '{rdata: '0, status: ST_PRIV_FAULT};
		end else if (state_q == S_ACCESS && cache_done_i) begin
			resp_q.status <= ST_OK;
			if (req_q.store) begin
				resp_q.rdata <= '0;                             // Stores return no data
			end else begin
				resp_q.rdata <= req_q.word ? cache_rdata_i : {24'b0, load_byte};
			end
		end
	end

	resp_hold_a: assert property (@(posedge clock) disable iff (reset_i)
		resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_o));

	ready_excl_a: assert property (@(posedge clock) disable iff (reset_i)
		!(req_ready_o && resp_valid_o));

endmodule

//--- hdl/mem_subsystem.sv
module mem_subsystem import mem_pkg::*; (
	input  logic              clock,
	input  logic              reset_i,
	input  logic              req_valid_i,
	output logic              req_ready_o,
	input  mem_req_t          req_i,
	output logic              resp_valid_o,
	input  logic              resp_ready_i,
	output mem_resp_t         resp_o,
	input  logic              tlb_we_i,
	input  tlb_entry_t        tlb_entry_i,
	output logic              mem_req_valid_o,
	input  logic              mem_req_ready_i,
	output line_req_t         mem_req_o,
	input  logic              mem_rvalid_i,
	input  logic [LINE_W-1:0] mem_rdata_i
);

	logic lookup_en;
	logic [VPN_W-1:0] lookup_vpn;
	logic tlb_hit;
	logic [PPN_W-1:0] tlb_ppn;
	logic tlb_kernel;
	logic cache_valid;
	logic cache_ready;
	cache_req_t cache_req;
	logic cache_done;
	logic [31:0] cache_rdata;

	mem_stage stage0 (
		.clock, .reset_i,
		.req_valid_i, .req_ready_o, .req_i,
		.resp_valid_o, .resp_ready_i, .resp_o,
		.lookup_en_o(lookup_en), .lookup_vpn_o(lookup_vpn),
		.tlb_hit_i(tlb_hit), .tlb_ppn_i(tlb_ppn), .tlb_kernel_i(tlb_kernel),
		.cache_valid_o(cache_valid), .cache_ready_i(cache_ready), .cache_req_o(cache_req),
		.cache_done_i(cache_done), .cache_rdata_i(cache_rdata)
	);

	dtlb dtlb0 (
		.clock, .reset_i,
		.lookup_en_i(lookup_en), .lookup_vpn_i(lookup_vpn),
		.hit_o(tlb_hit), .ppn_o(tlb_ppn), .kernel_o(tlb_kernel),
		.tlb_we_i, .tlb_entry_i
	);

	data_cache cache0 (
		.clock, .reset_i,
		.req_valid_i(cache_valid), .req_ready_o(cache_ready), .req_i(cache_req),
		.done_o(cache_done), .rdata_o(cache_rdata),
		.mem_req_valid_o, .mem_req_ready_i, .mem_req_o,
		.mem_rvalid_i, .mem_rdata_i
	);

endmodule

//--- src.f
hdl/mem_pkg.sv
hdl/dtlb.sv
hdl/data_cache.sv
hdl/mem_stage.sv
hdl/mem_subsystem.sv
bench/mem_model.sv
bench/mem_subsystem_tb.sv
